// File: hw/cpu_pkg.sv
package cpu_pkg;

  localparam int DATA_WIDTH     = 32;
  localparam int ADDR_WIDTH     = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int NUM_REGS       = 32;
  localparam int INSTR_BYTES    = 4;

  localparam logic [ADDR_WIDTH-1:0] RESET_PC = '0;

  // RV32I major opcodes
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
  localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE  = 7'b0100011;

  localparam logic [2:0] FUNCT3_ADD  = 3'b000;
  localparam logic [2:0] FUNCT3_SLT  = 3'b010;
  localparam logic [2:0] FUNCT3_XOR  = 3'b100;
  localparam logic [2:0] FUNCT3_OR   = 3'b110;
  localparam logic [2:0] FUNCT3_AND  = 3'b111;
  // Word size for LW and SW
  localparam logic [2:0] FUNCT3_WORD = 3'b010;
  localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;

  typedef logic [DATA_WIDTH-1:0] instr_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    alu_op_e                   op;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic                      writes;
    logic                      is_load;
    logic                      is_store;
    logic [DATA_WIDTH-1:0]     a;
    logic [DATA_WIDTH-1:0]     b;
    logic [DATA_WIDTH-1:0]     store_data;
  } dec_alu_t;

  typedef struct packed {
    logic                      is_load;
    logic                      is_store;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [ADDR_WIDTH-1:0]     addr;
    logic [DATA_WIDTH-1:0]     store_data;
  } alu_mem_t;

  typedef struct packed {
    logic                  rd;
    logic                  wr;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                      en;
    logic [REG_ADDR_WIDTH-1:0] idx;
    logic [DATA_WIDTH-1:0]     data;
  } rf_write_t;

endpackage

// File: hw/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic stall_i,
  input  logic valid_i,
  input  T     data_i,
  output logic valid_o,
  output T     data_o
);

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      data_o <= data_i;
    end
  end

endmodule

// File: hw/rbank.sv
`timescale 1ns/1ps

module rbank (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rd_a_i,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rd_b_i,
  input  cpu_pkg::rf_write_t                 wr_i,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     rd_a_data_o,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     rd_b_data_o
);

  logic [cpu_pkg::DATA_WIDTH-1:0] regs_q [cpu_pkg::NUM_REGS];

  // x0 is cleared on reset and never written
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_i.en && (wr_i.idx != '0)) begin
      regs_q[wr_i.idx] <= wr_i.data;
    end
  end

  assign rd_a_data_o = regs_q[rd_a_i];
  assign rd_b_data_o = regs_q[rd_b_i];

endmodule

// File: hw/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
  input  logic                               dec_valid_i,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] dec_rs1_i,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] dec_rs2_i,
  input  logic                               dec_uses_rs2_i,
  input  logic                               alu_valid_i,
  input  logic                               alu_writes_i,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] alu_rd_i,
  input  logic                               mem_valid_i,
  input  logic                               mem_writes_i,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] mem_rd_i,
  input  logic                               mem_busy_i,
  output logic                               stall_fetch_o,
  output logic                               stall_decode_o,
  output logic                               stall_alu_o
);

  logic raw_alu;
  logic raw_mem;

  // x0 never creates a dependency
  assign raw_alu = alu_valid_i && alu_writes_i && (alu_rd_i != '0) &&
                   ((dec_rs1_i == alu_rd_i) || (dec_uses_rs2_i && (dec_rs2_i == alu_rd_i)));
  assign raw_mem = mem_valid_i && mem_writes_i && (mem_rd_i != '0) &&
                   ((dec_rs1_i == mem_rd_i) || (dec_uses_rs2_i && (dec_rs2_i == mem_rd_i)));

  // ALU only waits on memory, so a RAW stall leaves a bubble behind decode
  assign stall_alu_o    = mem_busy_i;
  assign stall_decode_o = mem_busy_i || (dec_valid_i && (raw_alu || raw_mem));
  assign stall_fetch_o  = stall_decode_o;

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              mem_req_busy_i,
  input  logic              stall_i,
  input  logic              instr_valid_i,
  input  cpu_pkg::instr_t   instr_i,
  output cpu_pkg::mem_req_t req_o,
  output logic              dec_valid_o,
  output cpu_pkg::instr_t   dec_instr_o
);

  logic                           started_q;
  logic                           pending_q;
  logic                           buf_valid_q;
  logic                           issue;
  logic [cpu_pkg::ADDR_WIDTH-1:0] pc_q;
  cpu_pkg::instr_t                buf_q;

  // Held off for the first cycle out of reset
  assign issue = started_q && !pending_q && !buf_valid_q && !mem_req_busy_i;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      started_q   <= 1'b0;
      pending_q   <= 1'b0;
      buf_valid_q <= 1'b0;
      pc_q        <= cpu_pkg::RESET_PC;
    end else begin
      started_q <= 1'b1;
      if (issue) begin
        pending_q <= 1'b1;
        pc_q      <= pc_q + cpu_pkg::ADDR_WIDTH'(cpu_pkg::INSTR_BYTES);
      end else if (instr_valid_i) begin
        pending_q <= 1'b0;
      end
      if (instr_valid_i) begin
        buf_valid_q <= 1'b1;
      end else if (buf_valid_q && !stall_i) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      buf_q <= instr_i;
    end
  end

  assign req_o       = '{rd: issue, wr: 1'b0, addr: pc_q, wdata: '0};
  assign dec_valid_o = buf_valid_q;
  assign dec_instr_o = buf_q;

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                               valid_i,
  input  cpu_pkg::instr_t                    instr_i,
  output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs1_o,
  output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs2_o,
  output logic                               uses_rs2_o,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     rs1_data_i,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     rs2_data_i,
  output logic                               valid_o,
  output cpu_pkg::dec_alu_t                  payload_o
);

  logic [6:0]                     opcode;
  logic [2:0]                     funct3;
  logic [6:0]                     funct7;
  logic [cpu_pkg::DATA_WIDTH-1:0] imm_i;
  logic [cpu_pkg::DATA_WIDTH-1:0] imm_s;
  logic [cpu_pkg::DATA_WIDTH-1:0] imm_u;
  logic                           known;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rs2_o  = instr_i[24:20];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u = {instr_i[31:12], 12'b0};

  always_comb begin
    known                = 1'b1;
    rs1_o                = instr_i[19:15];
    uses_rs2_o           = 1'b0;
    payload_o.op         = cpu_pkg::ALU_ADD;
    payload_o.rd         = instr_i[11:7];
    payload_o.writes     = 1'b0;
    payload_o.is_load    = 1'b0;
    payload_o.is_store   = 1'b0;
    payload_o.a          = rs1_data_i;
    payload_o.b          = imm_i;
    payload_o.store_data = rs2_data_i;
    case (opcode)
      cpu_pkg::OPCODE_OP: begin
        uses_rs2_o       = 1'b1;
        payload_o.writes = 1'b1;
        payload_o.b      = rs2_data_i;
        case (funct3)
          cpu_pkg::FUNCT3_ADD: begin
            payload_o.op = (funct7 == cpu_pkg::FUNCT7_SUB) ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
          end
          cpu_pkg::FUNCT3_SLT: payload_o.op = cpu_pkg::ALU_SLT;
          cpu_pkg::FUNCT3_XOR: payload_o.op = cpu_pkg::ALU_XOR;
          cpu_pkg::FUNCT3_OR:  payload_o.op = cpu_pkg::ALU_OR;
          cpu_pkg::FUNCT3_AND: payload_o.op = cpu_pkg::ALU_AND;
          default:             known = 1'b0;
        endcase
      end
      // Only ADDI of the immediate group
      cpu_pkg::OPCODE_OP_IMM: begin
        payload_o.writes = 1'b1;
        known            = (funct3 == cpu_pkg::FUNCT3_ADD);
      end
      cpu_pkg::OPCODE_LUI: begin
        rs1_o            = '0;
        payload_o.op     = cpu_pkg::ALU_PASS_B;
        payload_o.b      = imm_u;
        payload_o.writes = 1'b1;
      end
      cpu_pkg::OPCODE_LOAD: begin
        payload_o.writes  = 1'b1;
        payload_o.is_load = 1'b1;
        known             = (funct3 == cpu_pkg::FUNCT3_WORD);
      end
      cpu_pkg::OPCODE_STORE: begin
        uses_rs2_o         = 1'b1;
        payload_o.is_store = 1'b1;
        payload_o.b        = imm_s;
        known              = (funct3 == cpu_pkg::FUNCT3_WORD);
      end
      default: known = 1'b0;
    endcase
  end

  // Unknown words drop out here as bubbles
  assign valid_o = valid_i && known;

endmodule

// File: hw/alu_stage.sv
`timescale 1ns/1ps

module alu_stage (
  input  logic               valid_i,
  input  logic               stall_i,
  input  cpu_pkg::dec_alu_t  payload_i,
  output cpu_pkg::rf_write_t rf_wr_o,
  output logic               mem_valid_o,
  output cpu_pkg::alu_mem_t  mem_payload_o
);

  logic [cpu_pkg::DATA_WIDTH-1:0] result;
  logic                           advance;

  always_comb begin
    case (payload_i.op)
      cpu_pkg::ALU_SUB:    result = payload_i.a - payload_i.b;
      cpu_pkg::ALU_AND:    result = payload_i.a & payload_i.b;
      cpu_pkg::ALU_OR:     result = payload_i.a | payload_i.b;
      cpu_pkg::ALU_XOR:    result = payload_i.a ^ payload_i.b;
      cpu_pkg::ALU_SLT: begin
        result = cpu_pkg::DATA_WIDTH'($signed(payload_i.a) < $signed(payload_i.b));
      end
      cpu_pkg::ALU_PASS_B: result = payload_i.b;
      default:             result = payload_i.a + payload_i.b;
    endcase
  end

  assign advance = valid_i && !stall_i;

  // Loads leave their write to the memory stage
  assign rf_wr_o = '{en:   advance && payload_i.writes && !payload_i.is_load,
                     idx:  payload_i.rd,
                     data: result};

  // Nothing repeats into memory while held
  assign mem_valid_o   = advance && (payload_i.is_load || payload_i.is_store);
  assign mem_payload_o = '{is_load:    payload_i.is_load,
                           is_store:   payload_i.is_store,
                           rd:         payload_i.rd,
                           addr:       result,
                           store_data: payload_i.store_data};

endmodule

// File: hw/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           valid_i,
  input  cpu_pkg::alu_mem_t              payload_i,
  input  logic                           data_valid_i,
  input  logic [cpu_pkg::DATA_WIDTH-1:0] data_i,
  output cpu_pkg::mem_req_t              req_o,
  output logic                           busy_o,
  output cpu_pkg::rf_write_t             rf_wr_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_WAIT,
    ST_WRITE
  } state_e;

  state_e                             state_q;
  state_e                             state;
  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rd_q;
  logic [cpu_pkg::DATA_WIDTH-1:0]     data_q;

  // New entry is served in the cycle it arrives
  assign state = (state_q == ST_IDLE && valid_i) ? ST_REQUEST : state_q;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state)
        ST_REQUEST: state_q <= payload_i.is_load ? ST_WAIT : ST_IDLE;
        ST_WAIT: begin
          if (data_valid_i) begin
            state_q <= ST_WRITE;
          end
        end
        default:    state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == ST_REQUEST) begin
      rd_q <= payload_i.rd;
    end
    if (state == ST_WAIT && data_valid_i) begin
      data_q <= data_i;
    end
  end

  assign req_o = '{rd:    (state == ST_REQUEST) && payload_i.is_load,
                   wr:    (state == ST_REQUEST) && payload_i.is_store,
                   addr:  payload_i.addr,
                   wdata: payload_i.store_data};

  assign busy_o  = (state != ST_IDLE);
  assign rf_wr_o = '{en: (state == ST_WRITE), idx: rd_q, data: data_q};

endmodule

// File: hw/cpu.sv
`timescale 1ns/1ps

module cpu (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           mem_data_valid_i,
  input  logic                           mem_data_is_instr_i,
  input  logic [cpu_pkg::DATA_WIDTH-1:0] mem_data_i,
  output logic                           rd_req_valid_o,
  output logic                           wr_req_valid_o,
  output logic                           req_is_instr_o,
  output logic [cpu_pkg::ADDR_WIDTH-1:0] req_address_o,
  output logic [cpu_pkg::DATA_WIDTH-1:0] wr_data_o
);

  cpu_pkg::mem_req_t                  fetch_req;
  cpu_pkg::mem_req_t                  mem_req;
  cpu_pkg::mem_req_t                  port_req;
  logic                               sel_mem;
  logic                               fetch_stall;
  logic                               dec_stall;
  logic                               alu_stall;
  logic                               fetch_req_busy;
  logic                               fetch_valid;
  cpu_pkg::instr_t                    fetch_instr;
  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs1;
  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs2;
  logic                               uses_rs2;
  logic [cpu_pkg::DATA_WIDTH-1:0]     rs1_data;
  logic [cpu_pkg::DATA_WIDTH-1:0]     rs2_data;
  logic                               dec_valid;
  cpu_pkg::dec_alu_t                  dec_payload;
  logic                               alu_valid;
  cpu_pkg::dec_alu_t                  alu_payload;
  logic                               alu_mem_valid;
  cpu_pkg::alu_mem_t                  alu_mem_payload;
  logic                               mem_valid;
  cpu_pkg::alu_mem_t                  mem_payload;
  logic                               mem_busy;
  cpu_pkg::rf_write_t                 alu_rf_wr;
  cpu_pkg::rf_write_t                 mem_rf_wr;
  cpu_pkg::rf_write_t                 rf_wr;

  // Keeps a load from issuing while an instruction read is outstanding
  assign fetch_req_busy = mem_busy || (alu_valid && alu_payload.is_load);

  hazard_unit i_hazard_unit (
    .dec_valid_i    (dec_valid),
    .dec_rs1_i      (rs1),
    .dec_rs2_i      (rs2),
    .dec_uses_rs2_i (uses_rs2),
    .alu_valid_i    (alu_valid),
    .alu_writes_i   (alu_payload.writes),
    .alu_rd_i       (alu_payload.rd),
    .mem_valid_i    (mem_valid),
    .mem_writes_i   (mem_payload.is_load),
    .mem_rd_i       (mem_payload.rd),
    .mem_busy_i     (mem_busy),
    .stall_fetch_o  (fetch_stall),
    .stall_decode_o (dec_stall),
    .stall_alu_o    (alu_stall)
  );

  fetch_stage i_fetch_stage (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .mem_req_busy_i (fetch_req_busy),
    .stall_i        (fetch_stall),
    .instr_valid_i  (mem_data_valid_i && mem_data_is_instr_i),
    .instr_i        (mem_data_i),
    .req_o          (fetch_req),
    .dec_valid_o    (fetch_valid),
    .dec_instr_o    (fetch_instr)
  );

  decode_stage i_decode_stage (
    .valid_i    (fetch_valid),
    .instr_i    (fetch_instr),
    .rs1_o      (rs1),
    .rs2_o      (rs2),
    .uses_rs2_o (uses_rs2),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .valid_o    (dec_valid),
    .payload_o  (dec_payload)
  );

  pipe_reg #(.T(cpu_pkg::dec_alu_t)) i_dec_alu_reg (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .stall_i (alu_stall),
    .valid_i (dec_valid && !dec_stall),
    .data_i  (dec_payload),
    .valid_o (alu_valid),
    .data_o  (alu_payload)
  );

  alu_stage i_alu_stage (
    .valid_i       (alu_valid),
    .stall_i       (alu_stall),
    .payload_i     (alu_payload),
    .rf_wr_o       (alu_rf_wr),
    .mem_valid_o   (alu_mem_valid),
    .mem_payload_o (alu_mem_payload)
  );

  // Memory stage copies what it needs, so this register never holds
  pipe_reg #(.T(cpu_pkg::alu_mem_t)) i_alu_mem_reg (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .stall_i (1'b0),
    .valid_i (alu_mem_valid),
    .data_i  (alu_mem_payload),
    .valid_o (mem_valid),
    .data_o  (mem_payload)
  );

  mem_stage i_mem_stage (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .valid_i      (mem_valid),
    .payload_i    (mem_payload),
    .data_valid_i (mem_data_valid_i && !mem_data_is_instr_i),
    .data_i       (mem_data_i),
    .req_o        (mem_req),
    .busy_o       (mem_busy),
    .rf_wr_o      (mem_rf_wr)
  );

  rbank i_rbank (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rd_a_i      (rs1),
    .rd_b_i      (rs2),
    .wr_i        (rf_wr),
    .rd_a_data_o (rs1_data),
    .rd_b_data_o (rs2_data)
  );

  // Memory stage wins the shared port
  assign sel_mem  = mem_req.rd || mem_req.wr;
  assign port_req = sel_mem ? mem_req : fetch_req;

  assign rd_req_valid_o = port_req.rd;
  assign wr_req_valid_o = port_req.wr;
  assign req_is_instr_o = !sel_mem && fetch_req.rd;
  assign req_address_o  = port_req.addr;
  assign wr_data_o      = port_req.wdata;

  assign rf_wr = mem_rf_wr.en ? mem_rf_wr : alu_rf_wr;

endmodule

// File: test/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model #(
  parameter int WORDS = 512
) (
  input  logic        clk_i,
  input  logic        rd_req_valid_i,
  input  logic        wr_req_valid_i,
  input  logic        req_is_instr_i,
  input  logic [31:0] req_address_i,
  input  logic [31:0] wr_data_i,
  output logic        data_valid_o,
  output logic        data_is_instr_o,
  output logic [31:0] data_o
);

  localparam int IDX_W = $clog2(WORDS);

  logic [31:0]      mem_q [WORDS];
  logic             busy;
  logic             resp_now;
  int unsigned      delay;
  logic [31:0]      resp_data;
  logic             resp_instr;
  logic [IDX_W-1:0] idx;

  initial begin
    busy            = 1'b0;
    resp_now        = 1'b0;
    delay           = 0;
    resp_data       = '0;
    resp_instr      = 1'b0;
    data_valid_o    = 1'b0;
    data_is_instr_o = 1'b0;
    data_o          = '0;
  end

  // Requests are stable by the falling edge, answers change there too
  always @(negedge clk_i) begin
    idx      = req_address_i[IDX_W+1:2];
    resp_now = 1'b0;
    if (busy) begin
      delay = delay - 1;
      if (delay == 0) begin
        busy     = 1'b0;
        resp_now = 1'b1;
      end
    end
    // Read data taken when the request is seen
    if (rd_req_valid_i === 1'b1) begin
      busy       = 1'b1;
      delay      = $urandom_range(4, 1);
      resp_data  = mem_q[idx];
      resp_instr = req_is_instr_i;
    end
    if (wr_req_valid_i === 1'b1) begin
      mem_q[idx] = wr_data_i;
    end
    data_valid_o    <= resp_now;
    data_is_instr_o <= resp_instr;
    data_o          <= resp_data;
  end

endmodule

// File: test/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

  localparam int MEM_WORDS        = 512;
  localparam int DATA_BASE        = 'h400;
  localparam int MAX_STORES       = 64;
  localparam int DRAIN_CYCLES     = 20;
  localparam int CYCLES_PER_INSTR = 20;

  logic        clk_i;
  logic        rst_i;
  logic        data_valid;
  logic        data_is_instr;
  logic [31:0] data;
  logic        rd_req;
  logic        wr_req;
  logic        req_is_instr;
  logic [31:0] req_addr;
  logic [31:0] wr_data;

  logic [31:0] gold_regs [32];
  logic [31:0] gold_mem [MEM_WORDS];
  logic [31:0] exp_addr [MAX_STORES];
  logic [31:0] exp_data [MAX_STORES];
  int          n_instr;
  int          n_stores;
  int          cycles;
  int          since_rst;
  int          wr_count;
  logic        first_seen;
  logic        read_open;
  logic [31:0] next_pc;

  cpu i_dut (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .mem_data_valid_i    (data_valid),
    .mem_data_is_instr_i (data_is_instr),
    .mem_data_i          (data),
    .rd_req_valid_o      (rd_req),
    .wr_req_valid_o      (wr_req),
    .req_is_instr_o      (req_is_instr),
    .req_address_o       (req_addr),
    .wr_data_o           (wr_data)
  );

  tb_mem_model #(.WORDS(MEM_WORDS)) i_mem (
    .clk_i           (clk_i),
    .rd_req_valid_i  (rd_req),
    .wr_req_valid_i  (wr_req),
    .req_is_instr_i  (req_is_instr),
    .req_address_i   (req_addr),
    .wr_data_i       (wr_data),
    .data_valid_o    (data_valid),
    .data_is_instr_o (data_is_instr),
    .data_o          (data)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  function automatic logic [11:0] any_imm();
    return 12'($urandom);
  endfunction

  function automatic logic [11:0] data_offset();
    return 12'($urandom_range(63, 0) << 2);
  endfunction

  task automatic append_instr(input logic [31:0] word);
    i_mem.mem_q[n_instr] = word;
    n_instr++;
  endtask

  task automatic set_reg(input logic [4:0] rd, input logic [31:0] value);
    if (rd != 5'd0) begin
      gold_regs[rd] = value;
    end
  endtask

  task automatic alu_reg_op(input logic [2:0] f3, input logic [6:0] f7, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    a = gold_regs[rs1];
    b = gold_regs[rs2];
    case (f3)
      cpu_pkg::FUNCT3_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      cpu_pkg::FUNCT3_XOR: r = a ^ b;
      cpu_pkg::FUNCT3_OR:  r = a | b;
      cpu_pkg::FUNCT3_AND: r = a & b;
      default:             r = (f7 == cpu_pkg::FUNCT7_SUB) ? a - b : a + b;
    endcase
    set_reg(rd, r);
    append_instr({f7, rs2, rs1, f3, rd, cpu_pkg::OPCODE_OP});
  endtask

  task automatic add_imm(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    set_reg(rd, gold_regs[rs1] + {{20{imm[11]}}, imm});
    append_instr({imm, rs1, cpu_pkg::FUNCT3_ADD, rd, cpu_pkg::OPCODE_OP_IMM});
  endtask

  task automatic lui_op(input logic [4:0] rd, input logic [19:0] imm);
    set_reg(rd, {imm, 12'd0});
    append_instr({imm, rd, cpu_pkg::OPCODE_LUI});
  endtask

  task automatic load_word(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    logic [31:0] addr;
    addr = gold_regs[rs1] + {{20{imm[11]}}, imm};
    set_reg(rd, gold_mem[(addr >> 2) % MEM_WORDS]);
    append_instr({imm, rs1, cpu_pkg::FUNCT3_WORD, rd, cpu_pkg::OPCODE_LOAD});
  endtask

  task automatic store_word(input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] imm);
    logic [31:0] addr;
    addr = gold_regs[rs1] + {{20{imm[11]}}, imm};
    gold_mem[(addr >> 2) % MEM_WORDS] = gold_regs[rs2];
    exp_addr[n_stores] = addr;
    exp_data[n_stores] = gold_regs[rs2];
    n_stores++;
    append_instr({imm[11:5], rs2, rs1, cpu_pkg::FUNCT3_WORD, imm[4:0], cpu_pkg::OPCODE_STORE});
  endtask

  // Word outside the kept instruction set, aimed at a live register
  task automatic junk_word(input logic [4:0] rd, input logic [6:0] opcode, input logic [2:0] f3);
    append_instr({any_imm(), 5'd2, f3, rd, opcode});
  endtask

  task automatic fill_memory();
    logic [31:0] word;
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (i < DATA_BASE / 4) begin
        // ADDI x0, x0, index
        word = {12'(i), 5'd0, cpu_pkg::FUNCT3_ADD, 5'd0, cpu_pkg::OPCODE_OP_IMM};
      end else begin
        word = $urandom;
      end
      i_mem.mem_q[i] = word;
      gold_mem[i]    = word;
    end
  endtask

  task automatic build_program();
    logic [11:0] off;
    add_imm(5'd1, 5'd0, 12'(DATA_BASE));
    add_imm(5'd2, 5'd0, any_imm());
    lui_op(5'd3, 20'($urandom));
    add_imm(5'd3, 5'd3, any_imm());
    store_word(5'd2, 5'd1, data_offset());
    store_word(5'd3, 5'd1, data_offset());
    // Each result stored right behind its producer
    alu_reg_op(cpu_pkg::FUNCT3_ADD, 7'd0, 5'd4, 5'd2, 5'd3);
    store_word(5'd4, 5'd1, data_offset());
    alu_reg_op(cpu_pkg::FUNCT3_ADD, cpu_pkg::FUNCT7_SUB, 5'd5, 5'd2, 5'd3);
    store_word(5'd5, 5'd1, data_offset());
    alu_reg_op(cpu_pkg::FUNCT3_AND, 7'd0, 5'd6, 5'd2, 5'd3);
    store_word(5'd6, 5'd1, data_offset());
    alu_reg_op(cpu_pkg::FUNCT3_OR, 7'd0, 5'd7, 5'd2, 5'd3);
    store_word(5'd7, 5'd1, data_offset());
    alu_reg_op(cpu_pkg::FUNCT3_XOR, 7'd0, 5'd8, 5'd2, 5'd3);
    store_word(5'd8, 5'd1, data_offset());
    alu_reg_op(cpu_pkg::FUNCT3_SLT, 7'd0, 5'd9, 5'd2, 5'd3);
    store_word(5'd9, 5'd1, data_offset());
    alu_reg_op(cpu_pkg::FUNCT3_SLT, 7'd0, 5'd10, 5'd3, 5'd2);
    store_word(5'd10, 5'd1, data_offset());
    // Negative against positive, true only when signed
    add_imm(5'd19, 5'd0, {1'b1, 11'($urandom)});
    alu_reg_op(cpu_pkg::FUNCT3_SLT, 7'd0, 5'd20, 5'd19, 5'd1);
    store_word(5'd20, 5'd1, data_offset());
    junk_word(5'd2, 7'b0001011, 3'b000);
    junk_word(5'd3, cpu_pkg::OPCODE_OP_IMM, 3'b001);
    store_word(5'd2, 5'd1, data_offset());
    store_word(5'd3, 5'd1, data_offset());
    load_word(5'd11, 5'd1, data_offset());
    alu_reg_op(cpu_pkg::FUNCT3_ADD, 7'd0, 5'd12, 5'd11, 5'd2);
    store_word(5'd12, 5'd1, data_offset());
    load_word(5'd13, 5'd1, data_offset());
    store_word(5'd13, 5'd1, data_offset());
    alu_reg_op(cpu_pkg::FUNCT3_ADD, 7'd0, 5'd16, 5'd12, 5'd13);
    alu_reg_op(cpu_pkg::FUNCT3_XOR, 7'd0, 5'd16, 5'd16, 5'd4);
    alu_reg_op(cpu_pkg::FUNCT3_ADD, cpu_pkg::FUNCT7_SUB, 5'd17, 5'd16, 5'd5);
    add_imm(5'd17, 5'd17, any_imm());
    store_word(5'd17, 5'd1, data_offset());
    store_word(5'd0, 5'd1, data_offset());
    // Load back a word just stored
    off = data_offset();
    store_word(5'd9, 5'd1, off);
    load_word(5'd18, 5'd1, off);
    add_imm(5'd18, 5'd18, any_imm());
    store_word(5'd18, 5'd1, data_offset());
  endtask

  always @(posedge clk_i) begin
    if (!rst_i) begin
      since_rst  <= 0;
      first_seen <= 1'b0;
      read_open  <= 1'b0;
      next_pc    <= cpu_pkg::RESET_PC;
      wr_count   <= 0;
    end else begin
      if (since_rst < 2) begin
        since_rst <= since_rst + 1;
      end
      if (rd_req || wr_req) begin
        first_seen <= 1'b1;
      end
      if (rd_req) begin
        read_open <= 1'b1;
      end else if (data_valid) begin
        read_open <= 1'b0;
      end
      if (rd_req && req_is_instr) begin
        next_pc <= next_pc + cpu_pkg::INSTR_BYTES;
      end
      if (wr_req) begin
        wr_count <= wr_count + 1;
      end
    end
  end

  assert property (@(posedge clk_i) (!rst_i || since_rst == 0) |->
                   (rd_req !== 1'b1) && (wr_req !== 1'b1))
    else stop_with_failure("Request issued during reset or in the cycle after it");

  assert property (@(posedge clk_i) disable iff (!rst_i)
                   (rd_req || wr_req) && !first_seen |-> rd_req && req_is_instr)
    else stop_with_failure("First request is not an instruction read");

  assert property (@(posedge clk_i) disable iff (!rst_i)
                   rd_req && req_is_instr |-> req_addr == next_pc)
    else stop_with_failure($sformatf("FAIL fetch_address expected %h actual %h",
                                     $sampled(next_pc), $sampled(req_addr)));

  assert property (@(posedge clk_i) disable iff (!rst_i) rd_req |-> !read_open)
    else stop_with_failure("Read request issued while another read was unanswered");

  assert property (@(posedge clk_i) disable iff (!rst_i) !(rd_req && wr_req))
    else stop_with_failure("Read and write requests in the same cycle");

  assert property (@(posedge clk_i) disable iff (!rst_i) wr_req |-> wr_count < n_stores)
    else stop_with_failure("More write requests than SW instructions in the program");

  assert property (@(posedge clk_i) disable iff (!rst_i)
                   wr_req && wr_count < n_stores |-> req_addr == exp_addr[wr_count])
    else stop_with_failure($sformatf("FAIL store_address #%0d expected %h actual %h",
                                     $sampled(wr_count), exp_addr[$sampled(wr_count)],
                                     $sampled(req_addr)));

  assert property (@(posedge clk_i) disable iff (!rst_i)
                   wr_req && wr_count < n_stores |-> wr_data == exp_data[wr_count])
    else stop_with_failure($sformatf("FAIL store_data #%0d expected %h actual %h",
                                     $sampled(wr_count), exp_data[$sampled(wr_count)],
                                     $sampled(wr_data)));

  initial begin
    void'($urandom(32'hd3c8_c086));
    rst_i    = 1'b0;
    n_instr  = 0;
    n_stores = 0;
    cycles   = 0;
    for (int i = 0; i < 32; i++) begin
      gold_regs[i] = '0;
    end
    fill_memory();
    build_program();
    repeat (3) @(negedge clk_i);
    rst_i = 1'b1;
    while (wr_count < n_stores && cycles < n_instr * CYCLES_PER_INSTR) begin
      @(posedge clk_i);
      cycles++;
    end
    // Extra cycles catch stray writes after the last SW
    repeat (DRAIN_CYCLES) @(posedge clk_i);
    if (wr_count == n_stores) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_with_failure($sformatf("Timeout after %0d cycles with %0d of %0d stores seen",
                                  cycles, wr_count, n_stores));
    end
  end

endmodule

// File: list.f
hw/cpu_pkg.sv
hw/pipe_reg.sv
hw/rbank.sv
hw/hazard_unit.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/alu_stage.sv
hw/mem_stage.sv
hw/cpu.sv
test/tb_mem_model.sv
test/tb_cpu.sv

// File: Bender.yml
package:
  name: rv32i_pipe

sources:
  - hw/cpu_pkg.sv
  - hw/pipe_reg.sv
  - hw/rbank.sv
  - hw/hazard_unit.sv
  - hw/fetch_stage.sv
  - hw/decode_stage.sv
  - hw/alu_stage.sv
  - hw/mem_stage.sv
  - hw/cpu.sv
  - target: test
    files:
      - test/tb_mem_model.sv
      - test/tb_cpu.sv
